//--- hdl/pwm_settings.svh
`ifndef PWM_SETTINGS_SVH
`define PWM_SETTINGS_SVH

// ----------------------------------------------------------------------
// ML-KEM modulus and coefficient width
// ----------------------------------------------------------------------
`define PWM_Q 3329
`define PWM_COEFF_W 12

// ----------------------------------------------------------------------
// pipeline latencies in clock cycles
// ----------------------------------------------------------------------
// one masked modular multiply
`define PWM_MULT_LAT 3
// two multiplies in series, then the coefficient add and the w add
`define PWM_PIPE_LAT (2*`PWM_MULT_LAT+2)

// pair count width, so up to 255 pairs per run
`define PWM_CNT_W 8

`endif

//--- hdl/pwm_data_pkg.sv
`include "pwm_settings.svh"

package pwm_data_pkg;

    // one coefficient or one share of it, always below q
    typedef logic [`PWM_COEFF_W-1:0] coeff_t;

    // two arithmetic shares, value = (s0 + s1) mod q
    typedef struct packed {
        coeff_t s0;
        coeff_t s1;
    } shared_coeff_t;

    // operands of one pairwise product beat
    typedef struct packed {
        shared_coeff_t u0;
        shared_coeff_t u1;
        shared_coeff_t v0;
        shared_coeff_t v1;
        shared_coeff_t w0;
        shared_coeff_t w1;
        shared_coeff_t zeta;
    } pwm_operand_t;

    // res0 = u0*v0 + zeta*u1*v1 and res1 = u0*v1 + u1*v0, plus w when accumulating
    typedef struct packed {
        shared_coeff_t res0;
        shared_coeff_t res1;
    } pwm_result_t;

    // fresh random masks, one per multiplier
    typedef coeff_t [4:0] mask_vec_t;

endpackage

//--- hdl/pwm_ctrl_pkg.sv
`include "pwm_settings.svh"

package pwm_ctrl_pkg;

    // programmed number of pairs, or a running count of them
    typedef logic [`PWM_CNT_W-1:0] pair_count_t;

    // sequencer states
    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DRAIN,
        DONE
    } seq_state_t;

endpackage

//--- hdl/mask_lfsr.sv
`timescale 1ns/1ps
`include "pwm_settings.svh"

module mask_lfsr (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    zeroize,
    output pwm_data_pkg::mask_vec_t masks
);
    import pwm_data_pkg::*;

    localparam logic [63:0] SEED = 64'h5a3c_96e1_0f2d_b487;
    localparam coeff_t Q = coeff_t'(`PWM_Q);
    localparam int unsigned STEP = `PWM_COEFF_W;
    localparam int unsigned NUM_MASKS = $size(mask_vec_t);
    localparam int unsigned SHIFT = NUM_MASKS * STEP;

    logic [63:0] lfsr;
    logic [63:0] lfsr_next;

    // advance past all five slices each cycle so no mask is reused
    // taps 64, 63, 61, 60 give a maximal length sequence
    always_comb begin
        lfsr_next = lfsr;
        for (int i = 0; i < SHIFT; i++) begin
            lfsr_next = {lfsr_next[62:0],
                         lfsr_next[63] ^ lfsr_next[62] ^ lfsr_next[60] ^ lfsr_next[59]};
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            lfsr <= SEED;
        end else if (zeroize) begin
            lfsr <= SEED;
        end else begin
            lfsr <= lfsr_next;
        end
    end

    // one subtraction folds each 12-bit slice below q
    always_comb begin
        coeff_t slice;
        for (int i = 0; i < NUM_MASKS; i++) begin
            slice = lfsr[i*STEP +: STEP];
            masks[i] = (slice >= Q) ? coeff_t'(slice - Q) : slice;
        end
    end

endmodule

//--- hdl/masked_mod_mult.sv
`timescale 1ns/1ps
`include "pwm_settings.svh"

module masked_mod_mult (
    input  logic                        clk,
    input  logic                        reset_n,
    input  logic                        zeroize,
    input  pwm_data_pkg::shared_coeff_t x,
    input  pwm_data_pkg::shared_coeff_t y,
    input  pwm_data_pkg::coeff_t        mask,
    output pwm_data_pkg::shared_coeff_t z
);
    import pwm_data_pkg::*;

    localparam int unsigned Q = `PWM_Q;
    localparam int unsigned SUM_W = `PWM_COEFF_W + 2;

    // stage 1 share cross products, each below q
    coeff_t p00;
    coeff_t p01;
    coeff_t p10;
    coeff_t p11;

    // stage 2 remasked partial sums, each below 3q
    logic [SUM_W-1:0] sum0;
    logic [SUM_W-1:0] sum1;

    function automatic coeff_t mul_mod(coeff_t a, coeff_t b);
        logic [2*`PWM_COEFF_W-1:0] prod;
        prod = a * b;
        return coeff_t'(prod % Q);
    endfunction

    // bring a value below 4q back into [0, q)
    function automatic coeff_t fold_mod(logic [SUM_W-1:0] a);
        logic [SUM_W-1:0] r;
        if (a >= SUM_W'(3 * Q)) begin
            r = a - SUM_W'(3 * Q);
        end else if (a >= SUM_W'(2 * Q)) begin
            r = a - SUM_W'(2 * Q);
        end else if (a >= SUM_W'(Q)) begin
            r = a - SUM_W'(Q);
        end else begin
            r = a;
        end
        return coeff_t'(r);
    endfunction

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            p00  <= '0;
            p01  <= '0;
            p10  <= '0;
            p11  <= '0;
            sum0 <= '0;
            sum1 <= '0;
            z    <= '0;
        end else if (zeroize) begin
            p00  <= '0;
            p01  <= '0;
            p10  <= '0;
            p11  <= '0;
            sum0 <= '0;
            sum1 <= '0;
            z    <= '0;
        end else begin
            // stage 1
            p00 <= mul_mod(x.s0, y.s0);
            p01 <= mul_mod(x.s0, y.s1);
            p10 <= mul_mod(x.s1, y.s0);
            p11 <= mul_mod(x.s1, y.s1);
            // stage 2 adds the mask to one share and removes it from the other
            // so the plain product x*y never sits in one register
            sum0 <= SUM_W'(p00) + SUM_W'(p01) + SUM_W'(mask);
            sum1 <= SUM_W'(p10) + SUM_W'(p11) + SUM_W'(Q) - SUM_W'(mask);
            // stage 3
            z.s0 <= fold_mod(sum0);
            z.s1 <= fold_mod(sum1);
        end
    end

endmodule

//--- hdl/masked_pairwm.sv
`timescale 1ns/1ps
`include "pwm_settings.svh"

module masked_pairwm (
    input  logic                       clk,
    input  logic                       reset_n,
    input  logic                       zeroize,
    input  logic                       valid,
    input  logic                       accumulate,
    input  pwm_data_pkg::mask_vec_t    masks,
    input  pwm_data_pkg::pwm_operand_t operand,
    output logic                       out_valid,
    output pwm_data_pkg::pwm_result_t  result
);
    import pwm_data_pkg::*;

    localparam int unsigned Q = `PWM_Q;
    localparam int unsigned MULT_LAT = `PWM_MULT_LAT;
    localparam int unsigned PIPE_LAT = `PWM_PIPE_LAT;
    // w meets the coefficient sums one stage before the output
    localparam int unsigned W_LAT = PIPE_LAT - 1;

    // multiplier outputs
    shared_coeff_t u0v0;
    shared_coeff_t u0v1;
    shared_coeff_t u1v0;
    shared_coeff_t zeta_v1;
    shared_coeff_t u1_zv1;

    // delay lines, index 0 is the newest entry
    shared_coeff_t [MULT_LAT-1:0] u1_dly;
    shared_coeff_t [MULT_LAT-1:0] u0v0_dly;
    shared_coeff_t [MULT_LAT-1:0] u0v1_dly;
    shared_coeff_t [MULT_LAT-1:0] u1v0_dly;
    shared_coeff_t [W_LAT-1:0]    w0_dly;
    shared_coeff_t [W_LAT-1:0]    w1_dly;
    logic [W_LAT-1:0]             acc_dly;
    logic [PIPE_LAT-1:0]          valid_dly;

    shared_coeff_t uv0;
    shared_coeff_t uv1;
    shared_coeff_t w0_add;
    shared_coeff_t w1_add;

    function automatic coeff_t add_mod(coeff_t a, coeff_t b);
        logic [`PWM_COEFF_W:0] s;
        s = a + b;
        return (s >= Q) ? coeff_t'(s - Q) : coeff_t'(s);
    endfunction

    // shares add independently, the mask carries through
    function automatic shared_coeff_t add_shared(shared_coeff_t a, shared_coeff_t b);
        shared_coeff_t r;
        r.s0 = add_mod(a.s0, b.s0);
        r.s1 = add_mod(a.s1, b.s1);
        return r;
    endfunction

    // ------------------------------------------------------------------
    // stage A products
    // ------------------------------------------------------------------
    masked_mod_mult mult_u0_v0 (
        .clk     (clk),
        .reset_n (reset_n),
        .zeroize (zeroize),
        .x       (operand.u0),
        .y       (operand.v0),
        .mask    (masks[0]),
        .z       (u0v0)
    );

    masked_mod_mult mult_u0_v1 (
        .clk     (clk),
        .reset_n (reset_n),
        .zeroize (zeroize),
        .x       (operand.u0),
        .y       (operand.v1),
        .mask    (masks[1]),
        .z       (u0v1)
    );

    masked_mod_mult mult_u1_v0 (
        .clk     (clk),
        .reset_n (reset_n),
        .zeroize (zeroize),
        .x       (operand.u1),
        .y       (operand.v0),
        .mask    (masks[2]),
        .z       (u1v0)
    );

    masked_mod_mult mult_zeta_v1 (
        .clk     (clk),
        .reset_n (reset_n),
        .zeroize (zeroize),
        .x       (operand.zeta),
        .y       (operand.v1),
        .mask    (masks[3]),
        .z       (zeta_v1)
    );

    // ------------------------------------------------------------------
    // stage B, u1 arrives with zeta*v1
    // ------------------------------------------------------------------
    masked_mod_mult mult_u1_zv1 (
        .clk     (clk),
        .reset_n (reset_n),
        .zeroize (zeroize),
        .x       (u1_dly[MULT_LAT-1]),
        .y       (zeta_v1),
        .mask    (masks[4]),
        .z       (u1_zv1)
    );

    // zero goes in instead of w when not accumulating, same latency
    always_comb begin
        if (acc_dly[W_LAT-1]) begin
            w0_add = w0_dly[W_LAT-1];
            w1_add = w1_dly[W_LAT-1];
        end else begin
            w0_add = '0;
            w1_add = '0;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            u1_dly    <= '0;
            u0v0_dly  <= '0;
            u0v1_dly  <= '0;
            u1v0_dly  <= '0;
            w0_dly    <= '0;
            w1_dly    <= '0;
            acc_dly   <= '0;
            valid_dly <= '0;
            uv0       <= '0;
            uv1       <= '0;
            result    <= '0;
        end else if (zeroize) begin
            u1_dly    <= '0;
            u0v0_dly  <= '0;
            u0v1_dly  <= '0;
            u1v0_dly  <= '0;
            w0_dly    <= '0;
            w1_dly    <= '0;
            acc_dly   <= '0;
            valid_dly <= '0;
            uv0       <= '0;
            uv1       <= '0;
            result    <= '0;
        end else begin
            u1_dly    <= {u1_dly[MULT_LAT-2:0], operand.u1};
            u0v0_dly  <= {u0v0_dly[MULT_LAT-2:0], u0v0};
            u0v1_dly  <= {u0v1_dly[MULT_LAT-2:0], u0v1};
            u1v0_dly  <= {u1v0_dly[MULT_LAT-2:0], u1v0};
            w0_dly    <= {w0_dly[W_LAT-2:0], operand.w0};
            w1_dly    <= {w1_dly[W_LAT-2:0], operand.w1};
            acc_dly   <= {acc_dly[W_LAT-2:0], accumulate};
            valid_dly <= {valid_dly[PIPE_LAT-2:0], valid};
            // coefficient add
            uv0 <= add_shared(u0v0_dly[MULT_LAT-1], u1_zv1);
            uv1 <= add_shared(u0v1_dly[MULT_LAT-1], u1v0_dly[MULT_LAT-1]);
            // accumulate add
            result.res0 <= add_shared(uv0, w0_add);
            result.res1 <= add_shared(uv1, w1_add);
        end
    end

    assign out_valid = valid_dly[PIPE_LAT-1];

endmodule

//--- hdl/pair_counter.sv
`timescale 1ns/1ps

module pair_counter (
    input  logic                      clk,
    input  logic                      reset_n,
    input  logic                      zeroize,
    input  logic                      load,
    input  logic                      issue,
    input  logic                      retire,
    input  pwm_ctrl_pkg::pair_count_t num_pairs,
    output logic                      last_issued,
    output logic                      all_retired
);
    import pwm_ctrl_pkg::*;

    pair_count_t target;
    pair_count_t issued;
    pair_count_t retired;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            target  <= '0;
            issued  <= '0;
            retired <= '0;
        end else if (zeroize) begin
            target  <= '0;
            issued  <= '0;
            retired <= '0;
        end else if (load) begin
            target  <= num_pairs;
            issued  <= '0;
            retired <= '0;
        end else begin
            if (issue) begin
                issued <= issued + 1'b1;
            end
            if (retire) begin
                retired <= retired + 1'b1;
            end
        end
    end

    assign last_issued = (issued == target);

    // the result on out_valid this cycle already counts
    // so done follows the last result by one cycle
    assign all_retired = (retired == target) || (retire && (retired + 1'b1 == target));

endmodule

//--- hdl/pairwm_sequencer.sv
`timescale 1ns/1ps

module pairwm_sequencer (
    input  logic clk,
    input  logic reset_n,
    input  logic zeroize,
    input  logic start,
    input  logic in_valid,
    input  logic last_issued,
    input  logic all_retired,
    output logic load,
    output logic beat_accept,
    output logic busy,
    output logic done
);
    import pwm_ctrl_pkg::*;

    seq_state_t state;
    seq_state_t state_next;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state <= IDLE;
        end else if (zeroize) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (start) begin
                    state_next = RUN;
                end
            end
            RUN: begin
                // with zero pairs both flags are already set
                if (last_issued) begin
                    state_next = all_retired ? DONE : DRAIN;
                end
            end
            DRAIN: begin
                if (all_retired) begin
                    state_next = DONE;
                end
            end
            DONE: begin
                state_next = IDLE;
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    assign load = (state == IDLE) && start;

    // beats past the programmed count are dropped
    assign beat_accept = in_valid && (state == RUN) && !last_issued;

    assign busy = (state == RUN) || (state == DRAIN);
    assign done = (state == DONE);

endmodule

//--- hdl/pairwm_unit.sv
`timescale 1ns/1ps

module pairwm_unit (
    input  logic                       clk,
    input  logic                       reset_n,
    input  logic                       zeroize,
    input  logic                       start,
    input  logic                       accumulate,
    input  logic                       in_valid,
    input  pwm_ctrl_pkg::pair_count_t  num_pairs,
    input  pwm_data_pkg::pwm_operand_t operand,
    output logic                       out_valid,
    output logic                       busy,
    output logic                       done,
    output pwm_data_pkg::pwm_result_t  result
);
    import pwm_data_pkg::*;

    logic      load;
    logic      beat_accept;
    logic      last_issued;
    logic      all_retired;
    mask_vec_t masks;

    pairwm_sequencer u_sequencer (
        .clk         (clk),
        .reset_n     (reset_n),
        .zeroize     (zeroize),
        .start       (start),
        .in_valid    (in_valid),
        .last_issued (last_issued),
        .all_retired (all_retired),
        .load        (load),
        .beat_accept (beat_accept),
        .busy        (busy),
        .done        (done)
    );

    // results leaving the pipeline count as retired
    pair_counter u_counter (
        .clk         (clk),
        .reset_n     (reset_n),
        .zeroize     (zeroize),
        .load        (load),
        .issue       (beat_accept),
        .retire      (out_valid),
        .num_pairs   (num_pairs),
        .last_issued (last_issued),
        .all_retired (all_retired)
    );

    mask_lfsr u_lfsr (
        .clk     (clk),
        .reset_n (reset_n),
        .zeroize (zeroize),
        .masks   (masks)
    );

    masked_pairwm u_pairwm (
        .clk        (clk),
        .reset_n    (reset_n),
        .zeroize    (zeroize),
        .valid      (beat_accept),
        .accumulate (accumulate),
        .masks      (masks),
        .operand    (operand),
        .out_valid  (out_valid),
        .result     (result)
    );

endmodule

//--- testbench/pairwm_tb_model.svh
`ifndef PAIRWM_TB_MODEL_SVH
`define PAIRWM_TB_MODEL_SVH

// ----------------------------------------------------------------------
// reference model for one pairwise product beat
// ----------------------------------------------------------------------

// plain values of one beat before they are split into shares
typedef struct packed {
    coeff_t u0;
    coeff_t u1;
    coeff_t v0;
    coeff_t v1;
    coeff_t w0;
    coeff_t w1;
    coeff_t zeta;
} plain_beat_t;

// expected value sits in share 0, share 1 stays zero
function automatic pwm_result_t pairwise_ref(plain_beat_t b, bit acc);
    longint r0;
    longint r1;
    pwm_result_t r;
    r0 = longint'(b.u0) * b.v0 + longint'(b.zeta) * b.u1 * b.v1;
    r1 = longint'(b.u0) * b.v1 + longint'(b.u1) * b.v0;
    if (acc) begin
        r0 += b.w0;
        r1 += b.w1;
    end
    r = '0;
    r.res0.s0 = coeff_t'(r0 % `PWM_Q);
    r.res1.s0 = coeff_t'(r1 % `PWM_Q);
    return r;
endfunction

// r becomes share 0, share 1 carries the rest mod q
function automatic shared_coeff_t split_share(coeff_t value, coeff_t r);
    shared_coeff_t s;
    s.s0 = r;
    s.s1 = coeff_t'((`PWM_Q + value - r) % `PWM_Q);
    return s;
endfunction

function automatic coeff_t recombine(shared_coeff_t s);
    logic [`PWM_COEFF_W:0] sum;
    sum = s.s0 + s.s1;
    return coeff_t'(sum % `PWM_Q);
endfunction

// ----------------------------------------------------------------------
// compare tasks
// ----------------------------------------------------------------------
task automatic compare_result(input string name, input pwm_result_t expected,
                              input pwm_result_t actual);
    coeff_t exp0;
    coeff_t exp1;
    coeff_t act0;
    coeff_t act1;
    exp0 = recombine(expected.res0);
    exp1 = recombine(expected.res1);
    act0 = recombine(actual.res0);
    act1 = recombine(actual.res1);
    check_count++;
    if (act0 !== exp0) begin
        $display("MISMATCH at %0t ns: %s.res0 expected %0d, got %0d", $time, name, exp0, act0);
        error_count++;
    end
    if (act1 !== exp1) begin
        $display("MISMATCH at %0t ns: %s.res1 expected %0d, got %0d", $time, name, exp1, act1);
        error_count++;
    end
endtask

task automatic compare_flag(input string name, input logic expected, input logic actual);
    check_count++;
    if (actual !== expected) begin
        $display("MISMATCH at %0t ns: %s expected %b, got %b", $time, name, expected, actual);
        error_count++;
    end
endtask

`endif

//--- testbench/pairwm_tb.sv
`timescale 1ns/1ps
`include "pwm_settings.svh"

module pairwm_tb;
    import pwm_data_pkg::*;
    import pwm_ctrl_pkg::*;

    localparam int LAT = `PWM_PIPE_LAT;
    localparam int NUM_TESTS = 6;
    // beat slots over all tests including ignored beats and gaps
    localparam int TOTAL_BEATS = 4 + 32 + 24 + 16 + 14 + 14;
    localparam int WATCHDOG_CYCLES = TOTAL_BEATS + 20 * NUM_TESTS;

    logic         clk;
    logic         reset_n;
    logic         zeroize;
    logic         start;
    logic         accumulate;
    logic         in_valid;
    pair_count_t  num_pairs;
    pwm_operand_t operand;
    logic         out_valid;
    logic         busy;
    logic         done;
    pwm_result_t  result;

    integer seed = 32'h4422_8704;
    int error_count = 0;
    int check_count = 0;
    int test_count = 0;
    int test_start_errors = 0;
    int cycle = 0;
    int last_out_cycle = -1;
    int done_pulses = 0;
    bit acc_bit;
    logic [15:0] gap_pattern;

    // expected results in beat order with the cycle each one is due
    pwm_result_t exp_q[$];
    int due_q[$];

    `include "pairwm_tb_model.svh"

    pairwm_unit DUT (
        .clk        (clk),
        .reset_n    (reset_n),
        .zeroize    (zeroize),
        .start      (start),
        .accumulate (accumulate),
        .in_valid   (in_valid),
        .num_pairs  (num_pairs),
        .operand    (operand),
        .out_valid  (out_valid),
        .busy       (busy),
        .done       (done),
        .result     (result)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (out_valid) begin
            last_out_cycle <= cycle;
        end
        if (done) begin
            done_pulses <= done_pulses + 1;
        end
    end

    // ------------------------------------------------------------------
    // result checker
    // ------------------------------------------------------------------
    always @(negedge clk) begin : check_results
        pwm_result_t expected;
        int due;
        if (out_valid) begin
            if (exp_q.size() == 0) begin
                $display("ERROR at %0t ns: out_valid without an accepted beat", $time);
                error_count++;
            end else begin
                expected = exp_q.pop_front();
                due = due_q.pop_front();
                if (due != cycle) begin
                    $display("ERROR at %0t ns: result came in cycle %0d, expected in cycle %0d",
                             $time, cycle, due);
                    error_count++;
                end
                compare_result("result", expected, result);
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * 10);
        $display("TIMEOUT at %0t ns: tests did not finish in %0d cycles", $time, WATCHDOG_CYCLES);
        $display("FAIL: see errors above");
        $finish;
    end

    task automatic random_bit(output bit b);
        logic [31:0] r;
        r = $random(seed);
        b = r[0];
    endtask

    task automatic random_beat(output plain_beat_t b, output pwm_operand_t op);
        coeff_t r [14];
        for (int i = 0; i < 14; i++) begin
            r[i] = coeff_t'($unsigned($random(seed)) % `PWM_Q);
        end
        b = {r[0], r[1], r[2], r[3], r[4], r[5], r[6]};
        op.u0 = split_share(b.u0, r[7]);
        op.u1 = split_share(b.u1, r[8]);
        op.v0 = split_share(b.v0, r[9]);
        op.v1 = split_share(b.v1, r[10]);
        op.w0 = split_share(b.w0, r[11]);
        op.w1 = split_share(b.w1, r[12]);
        op.zeta = split_share(b.zeta, r[13]);
    endtask

    task automatic start_job(input pair_count_t n);
        @(posedge clk);
        start <= 1'b1;
        num_pairs <= n;
        @(posedge clk);
        start <= 1'b0;
        @(negedge clk);
        compare_flag("busy", 1'b1, busy);
    endtask

    // accept tells whether the DUT should take the beat in this slot
    task automatic drive_slot(input bit valid_in, input bit acc, input bit accept);
        plain_beat_t b;
        pwm_operand_t op;
        random_beat(b, op);
        @(posedge clk);
        in_valid <= valid_in;
        accumulate <= acc;
        operand <= op;
        // taken at the next edge with the result out LAT edges later
        if (valid_in && accept) begin
            exp_q.push_back(pairwise_ref(b, acc));
            due_q.push_back(cycle + LAT + 1);
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            in_valid <= 1'b0;
        end
    endtask

    task automatic check_drained();
        @(posedge clk);
        if (exp_q.size() != 0) begin
            $display("ERROR at %0t ns: %0d results never came out", $time, exp_q.size());
            error_count++;
            exp_q.delete();
            due_q.delete();
        end
    endtask

    task automatic finish_job(input int limit);
        int waited;
        int pulses_before;
        waited = 0;
        pulses_before = done_pulses;
        @(posedge clk);
        in_valid <= 1'b0;
        @(negedge clk);
        while (!done && waited < limit) begin
            @(negedge clk);
            waited++;
        end
        if (!done) begin
            $display("ERROR at %0t ns: done did not come within %0d cycles", $time, limit);
            error_count++;
        end else if (last_out_cycle != cycle - 1) begin
            $display("ERROR at %0t ns: done did not follow the last result by one cycle", $time);
            error_count++;
        end
        @(negedge clk);
        compare_flag("done", 1'b0, done);
        compare_flag("busy", 1'b0, busy);
        if (done_pulses != pulses_before + 1) begin
            $display("ERROR at %0t ns: done pulsed %0d times for one job", $time,
                     done_pulses - pulses_before);
            error_count++;
        end
        check_drained();
    endtask

    task automatic report_test(input string name);
        test_count++;
        if (error_count == test_start_errors) begin
            $display("test %0d %s: ok", test_count, name);
        end else begin
            $display("test %0d %s: %0d errors", test_count, name, error_count - test_start_errors);
        end
        test_start_errors = error_count;
    endtask

    // ------------------------------------------------------------------
    // tests
    // ------------------------------------------------------------------
    initial begin
        clk = 1'b0;
        reset_n = 1'b0;
        zeroize = 1'b0;
        start = 1'b0;
        accumulate = 1'b0;
        in_valid = 1'b0;
        num_pairs = '0;
        operand = '0;
        repeat (4) @(posedge clk);
        reset_n <= 1'b1;

        // beats without a start are ignored
        @(negedge clk);
        compare_flag("out_valid", 1'b0, out_valid);
        compare_flag("busy", 1'b0, busy);
        compare_flag("done", 1'b0, done);
        for (int i = 0; i < 4; i++) begin
            drive_slot(1'b1, 1'b0, 1'b0);
        end
        idle_cycles(LAT + 2);
        @(negedge clk);
        compare_flag("busy", 1'b0, busy);
        report_test("idle after reset");

        start_job(32);
        for (int i = 0; i < 32; i++) begin
            drive_slot(1'b1, 1'b0, 1'b1);
        end
        finish_job(LAT + 4);
        report_test("plain products");

        // first beats all accumulate and the rest mix per beat
        start_job(24);
        for (int i = 0; i < 24; i++) begin
            random_bit(acc_bit);
            drive_slot(1'b1, acc_bit || i < 8, 1'b1);
        end
        finish_job(LAT + 4);
        report_test("accumulate");

        // last slot always holds a beat so done comes after the slots
        gap_pattern = $random(seed);
        gap_pattern[15] = 1'b1;
        start_job(pair_count_t'($countones(gap_pattern)));
        for (int i = 0; i < 16; i++) begin
            random_bit(acc_bit);
            drive_slot(gap_pattern[i], acc_bit, 1'b1);
        end
        finish_job(LAT + 4);
        report_test("beats with gaps");

        start_job(10);
        for (int i = 0; i < 14; i++) begin
            random_bit(acc_bit);
            drive_slot(1'b1, acc_bit, i < 10);
        end
        finish_job(LAT + 4);
        report_test("extra beats");

        // zeroize before any result is due so nothing may come out
        start_job(20);
        for (int i = 0; i < 6; i++) begin
            drive_slot(1'b1, 1'b1, 1'b1);
        end
        @(posedge clk);
        in_valid <= 1'b0;
        zeroize <= 1'b1;
        exp_q.delete();
        due_q.delete();
        @(posedge clk);
        zeroize <= 1'b0;
        @(negedge clk);
        compare_flag("busy", 1'b0, busy);
        compare_flag("done", 1'b0, done);
        compare_flag("out_valid", 1'b0, out_valid);
        idle_cycles(LAT + 2);
        start_job(8);
        for (int i = 0; i < 8; i++) begin
            random_bit(acc_bit);
            drive_slot(1'b1, acc_bit, 1'b1);
        end
        finish_job(LAT + 4);
        report_test("zeroize and restart");

        $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- pairwm_unit.f
+incdir+hdl
+incdir+testbench
hdl/pwm_data_pkg.sv
hdl/pwm_ctrl_pkg.sv
hdl/mask_lfsr.sv
hdl/masked_mod_mult.sv
hdl/masked_pairwm.sv
hdl/pair_counter.sv
hdl/pairwm_sequencer.sv
hdl/pairwm_unit.sv
testbench/pairwm_tb.sv

//--- Bender.yml
package:
  name: pairwm_unit

sources:
  # design
  - include_dirs:
      - hdl
    files:
      - hdl/pwm_data_pkg.sv
      - hdl/pwm_ctrl_pkg.sv
      - hdl/mask_lfsr.sv
      - hdl/masked_mod_mult.sv
      - hdl/masked_pairwm.sv
      - hdl/pair_counter.sv
      - hdl/pairwm_sequencer.sv
      - hdl/pairwm_unit.sv
  # testbench
  - target: test
    include_dirs:
      - hdl
      - testbench
    files:
      - testbench/pairwm_tb.sv
